/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rbk_rf_ctrl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/rbk_cmd_fifo.sv */
`timescale 1ns/10ps

module rbk_cmd_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     autosa_core_clk,
  input  logic     autosa_core_rstn,
  input  logic     in_vld,
  input  payload_t in_pd,
  output logic     in_rdy,
  output logic     out_vld,
  output payload_t out_pd,
  input  logic     out_rdy
);
  import rbk_rf_pkg::*;

  localparam int DEPTH = RF_SLOTS;  // two commands can queue behind a running block
  localparam int PTR_W = $clog2(DEPTH);

  payload_t       mem [DEPTH];
  logic [PTR_W:0] wr_ptr;  // msb is the wrap bit
  logic [PTR_W:0] rd_ptr;
  logic           full;
  logic           push;
  logic           pop;

  assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign in_rdy  = ~full;
  assign out_vld = (wr_ptr != rd_ptr);  // entry shows the cycle after push
  assign out_pd  = mem[rd_ptr[PTR_W-1:0]];
  assign push    = in_vld & in_rdy;
  assign pop     = out_vld & out_rdy;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage
  always_ff @(posedge autosa_core_clk) begin
    if (push) mem[wr_ptr[PTR_W-1:0]] <= in_pd;
  end

  // upstream holds a refused command steady until it is taken
  a_in_hold: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    in_vld && !in_rdy |=> in_vld && $stable(in_pd));

endmodule

/* source/rbk_rf_ctrl.sv */
`timescale 1ns/10ps

module rbk_rf_ctrl #(
  parameter int DATA_W = 512,
  parameter int ADDR_W = 5
) (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  input  rbk_rf_pkg::rf_cfg_t    cfg,
  input  logic                   wr_cmd_vld,
  input  rbk_rf_pkg::rf_wr_cmd_t wr_cmd,
  output logic                   wr_cmd_rdy,
  input  logic                   rd_cmd_vld,
  input  rbk_rf_pkg::rf_rd_cmd_t rd_cmd,
  output logic                   rd_cmd_rdy,
  input  logic                   data_fifo_vld,
  input  logic [DATA_W-1:0]      data_fifo_pd,
  output logic                   data_fifo_rdy,
  output logic                   rf_wr_vld,
  output logic [ADDR_W-1:0]      rf_wr_addr,
  output logic [DATA_W-1:0]      rf_wr_data,
  output logic                   rf_wr_done,
  input  logic                   rf_wr_rdy,
  output logic                   rf_rd_vld,
  output logic [ADDR_W-1:0]      rf_rd_addr,
  output rbk_rf_pkg::rf_mask_t   rf_rd_mask,
  output logic                   rf_rd_done,
  input  logic                   rf_rd_rdy
);
  import rbk_rf_pkg::*;

  logic       wr_q_vld;  // queue to sequencer
  rf_wr_cmd_t wr_q_pd;
  logic       wr_q_rdy;
  logic       rd_q_vld;
  rf_rd_cmd_t rd_q_pd;
  logic       rd_q_rdy;
  logic       rf_full;
  logic       rf_nempty;

  //////////////////////////////
  // command queues
  rbk_cmd_fifo #(.payload_t(rf_wr_cmd_t)) u_wr_cmd_fifo (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .in_vld          (wr_cmd_vld),
    .in_pd           (wr_cmd),
    .in_rdy          (wr_cmd_rdy),
    .out_vld         (wr_q_vld),
    .out_pd          (wr_q_pd),
    .out_rdy         (wr_q_rdy)
  );

  rbk_cmd_fifo #(.payload_t(rf_rd_cmd_t)) u_rd_cmd_fifo (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .in_vld          (rd_cmd_vld),
    .in_pd           (rd_cmd),
    .in_rdy          (rd_cmd_rdy),
    .out_vld         (rd_q_vld),
    .out_pd          (rd_q_pd),
    .out_rdy         (rd_q_rdy)
  );

  //////////////////////////////
  // sequencers and occupancy
  rbk_rf_wr_seq #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_wr_seq (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .cfg             (cfg),
    .cmd_vld         (wr_q_vld),
    .cmd             (wr_q_pd),
    .cmd_rdy         (wr_q_rdy),
    .data_vld        (data_fifo_vld),
    .data_pd         (data_fifo_pd),
    .data_rdy        (data_fifo_rdy),
    .rf_wr_rdy       (rf_wr_rdy),
    .rf_full         (rf_full),
    .rf_wr_vld       (rf_wr_vld),
    .rf_wr_addr      (rf_wr_addr),
    .rf_wr_data      (rf_wr_data),
    .rf_wr_done      (rf_wr_done)
  );

  rbk_rf_rd_seq #(.ADDR_W(ADDR_W)) u_rd_seq (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .cfg             (cfg),
    .cmd_vld         (rd_q_vld),
    .cmd             (rd_q_pd),
    .cmd_rdy         (rd_q_rdy),
    .rf_rd_rdy       (rf_rd_rdy),
    .rf_nempty       (rf_nempty),
    .rf_rd_vld       (rf_rd_vld),
    .rf_rd_addr      (rf_rd_addr),
    .rf_rd_mask      (rf_rd_mask),
    .rf_rd_done      (rf_rd_done)
  );

  rbk_rf_slot_track u_slot_track (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .wr_done         (rf_wr_done),
    .rd_done         (rf_rd_done),
    .rf_full         (rf_full),
    .rf_nempty       (rf_nempty)
  );

endmodule

/* source/rbk_rf_pkg.sv */
package rbk_rf_pkg;

  //////////////////////////////
  // configuration
  typedef enum logic [1:0] {
    mode_contract = 2'd0,
    mode_split    = 2'd1  // 2'd2 kept back for merge
  } rubik_mode_e;

  typedef enum logic [1:0] {
    prec_byte = 2'd0,
    prec_half = 2'd1
  } precision_e;

  // quasi static, only touched while both sequencers idle
  typedef struct packed {
    rubik_mode_e mode;
    precision_e  precision;
  } rf_cfg_t;

  //////////////////////////////
  // commands, sizes minus one
  typedef struct packed {
    logic [4:0] row_m1;
    logic [5:0] col_m1;  // in 32-byte atoms
  } rf_wr_cmd_t;

  typedef struct packed {
    logic [5:0] row_m1;
    logic [5:0] col_m1;  // atoms in contract, elements in split
  } rf_rd_cmd_t;

  // valid byte count per atom of one read beat
  typedef struct packed {
    logic [5:0] atom1_bytes;
    logic [5:0] atom0_bytes;
  } rf_mask_t;

  localparam int ATOM_BYTES          = 32;
  localparam int CONTRACT_ROW_STRIDE = 4;  // entries per row step
  localparam int SPLIT_ROW_STRIDE    = 2;  // half-word split only
  localparam int RF_SLOTS            = 2;  // blocks held by the register file

endpackage

/* source/rbk_rf_rd_seq.sv */
`timescale 1ns/10ps

module rbk_rf_rd_seq #(
  parameter int ADDR_W = 5
) (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  input  rbk_rf_pkg::rf_cfg_t    cfg,
  input  logic                   cmd_vld,
  input  rbk_rf_pkg::rf_rd_cmd_t cmd,
  output logic                   cmd_rdy,
  input  logic                   rf_rd_rdy,
  input  logic                   rf_nempty,
  output logic                   rf_rd_vld,
  output logic [ADDR_W-1:0]      rf_rd_addr,
  output rbk_rf_pkg::rf_mask_t   rf_rd_mask,
  output logic                   rf_rd_done
);
  import rbk_rf_pkg::*;

  logic       cmd_pop;
  logic       pop_hold;
  logic       blk_open;
  logic [6:0] total_col;  // atoms or elements, per mode
  logic [6:0] total_row;
  logic       m_contract;
  logic       m_half;
  logic [5:0] row_beats;
  logic [4:0] ccnt;
  logic [5:0] ccnt_inc;
  logic [5:0] rcnt;
  logic [6:0] rcnt_inc;
  logic       col_end;
  logic       blk_end;
  logic [6:0] rem_col;
  logic [7:0] row_bytes;
  logic [7:0] rem_byte;
  rf_mask_t   contract_mask;
  rf_mask_t   split_mask;

  assign m_contract = (cfg.mode == mode_contract);
  assign m_half     = (cfg.precision == prec_half);

  //////////////////////////////
  // command pop
  assign cmd_rdy = blk_end | pop_hold;
  assign cmd_pop = cmd_vld & cmd_rdy;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      pop_hold  <= 1'b1;
      blk_open  <= 1'b0;
      total_col <= '0;
      total_row <= '0;
    end else begin
      if (pop_hold & cmd_vld) pop_hold <= 1'b0;
      else if (blk_end & ~cmd_vld) pop_hold <= 1'b1;
      if (cmd_pop) begin
        blk_open  <= 1'b1;
        total_col <= {1'b0, cmd.col_m1} + 7'd1;
        total_row <= {1'b0, cmd.row_m1} + 7'd1;
      end else if (blk_end) begin
        blk_open <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // beats, counters, address
  assign rf_rd_vld  = rf_rd_rdy & rf_nempty & blk_open;
  assign rf_rd_done = blk_end;

  assign row_beats = m_contract ? total_col[6:1] + {5'd0, total_col[0]} :
                     (m_half && total_col > 7'd32) ? 6'd4 : 6'd2;
  assign ccnt_inc  = {1'b0, ccnt} + 6'd1;
  assign rcnt_inc  = {1'b0, rcnt} + 7'd1;
  assign col_end   = rf_rd_vld & (ccnt_inc == row_beats);
  assign blk_end   = col_end & (rcnt_inc == total_row);

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      ccnt       <= '0;
      rcnt       <= '0;
      rf_rd_addr <= '0;
    end else begin
      if (col_end) ccnt <= '0;
      else if (rf_rd_vld) ccnt <= ccnt_inc[4:0];
      if (blk_end) rcnt <= '0;
      else if (col_end) rcnt <= rcnt_inc[5:0];
      if (blk_end) rf_rd_addr <= '0;
      else if (col_end && m_contract)
        rf_rd_addr <= ADDR_W'(rcnt_inc * CONTRACT_ROW_STRIDE);
      else if (col_end && m_half)
        rf_rd_addr <= ADDR_W'(rcnt_inc * SPLIT_ROW_STRIDE);
      else if (rf_rd_vld) rf_rd_addr <= rf_rd_addr + 1'b1;
    end
  end

  //////////////////////////////
  // byte mask
  assign rem_col = total_col - {1'b0, ccnt, 1'b0};  // columns left at this beat
  assign contract_mask.atom1_bytes = (rem_col == 7'd1) ? 6'd0 : 6'(ATOM_BYTES);
  assign contract_mask.atom0_bytes = 6'(ATOM_BYTES);

  assign row_bytes = m_half ? {total_col, 1'b0} : {1'b0, total_col};
  assign rem_byte  = (row_bytes > {ccnt[1:0], 6'd0}) ?
                     row_bytes - {ccnt[1:0], 6'd0} : 8'd0;  // 64 bytes per beat

  always_comb begin
    split_mask = '0;
    if (rem_byte >= 8'(2 * ATOM_BYTES)) begin
      split_mask.atom1_bytes = 6'(ATOM_BYTES);
      split_mask.atom0_bytes = 6'(ATOM_BYTES);
    end else if (rem_byte >= 8'(ATOM_BYTES)) begin
      split_mask.atom1_bytes = 6'(rem_byte - 8'(ATOM_BYTES));  // partial second atom
      split_mask.atom0_bytes = 6'(ATOM_BYTES);
    end else begin
      split_mask.atom0_bytes = rem_byte[5:0];
    end
  end

  assign rf_rd_mask = m_contract ? contract_mask : split_mask;

  // each fresh block starts reading from entry 0
  a_blk_start_addr: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    $rose(blk_open) |-> rf_rd_addr == '0);

endmodule

/* source/rbk_rf_slot_track.sv */
`timescale 1ns/10ps

module rbk_rf_slot_track (
  input  logic autosa_core_clk,
  input  logic autosa_core_rstn,
  input  logic wr_done,
  input  logic rd_done,
  output logic rf_full,
  output logic rf_nempty
);

  logic [1:0] wr_ptr;  // slot index plus wrap bit
  logic [1:0] rd_ptr;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_done) wr_ptr <= wr_ptr + 2'd1;
      if (rd_done) rd_ptr <= rd_ptr + 2'd1;
    end
  end

  assign rf_full   = (wr_ptr[1] ^ rd_ptr[1]) & (wr_ptr[0] == rd_ptr[0]);
  assign rf_nempty = (wr_ptr != rd_ptr);  // at least one block written, unread

  // sequencers must hold off on the tracker status
  a_no_wr_overflow: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    rf_full |-> !wr_done);
  a_no_rd_underflow: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !rf_nempty |-> !rd_done);

endmodule

/* source/rbk_rf_wr_seq.sv */
`timescale 1ns/10ps

module rbk_rf_wr_seq #(
  parameter int DATA_W = 512,
  parameter int ADDR_W = 5
) (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  input  rbk_rf_pkg::rf_cfg_t    cfg,
  input  logic                   cmd_vld,
  input  rbk_rf_pkg::rf_wr_cmd_t cmd,
  output logic                   cmd_rdy,
  input  logic                   data_vld,
  input  logic [DATA_W-1:0]      data_pd,
  output logic                   data_rdy,
  input  logic                   rf_wr_rdy,
  input  logic                   rf_full,
  output logic                   rf_wr_vld,
  output logic [ADDR_W-1:0]      rf_wr_addr,
  output logic [DATA_W-1:0]      rf_wr_data,
  output logic                   rf_wr_done
);
  import rbk_rf_pkg::*;

  logic       cmd_pop;
  logic       pop_hold;   // idle, next command pops at once
  logic       blk_open;
  logic [6:0] total_col;
  logic [5:0] total_row;
  logic [5:0] row_beats;
  logic [4:0] ccnt;
  logic [5:0] ccnt_inc;
  logic [4:0] rcnt;
  logic [5:0] rcnt_inc;
  logic       wr_beat;
  logic       col_end;
  logic       blk_end;

  //////////////////////////////
  // command pop
  assign cmd_rdy = blk_end | pop_hold;  // last beat pops the next one, no bubble
  assign cmd_pop = cmd_vld & cmd_rdy;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      pop_hold  <= 1'b1;
      blk_open  <= 1'b0;
      total_col <= '0;
      total_row <= '0;
    end else begin
      if (pop_hold & cmd_vld) pop_hold <= 1'b0;
      else if (blk_end & ~cmd_vld) pop_hold <= 1'b1;
      if (cmd_pop) begin
        blk_open  <= 1'b1;
        total_col <= {1'b0, cmd.col_m1} + 7'd1;
        total_row <= {1'b0, cmd.row_m1} + 6'd1;
      end else if (blk_end) begin
        blk_open <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // beats and counters
  assign wr_beat    = blk_open & rf_wr_rdy & ~rf_full & data_vld;
  assign data_rdy   = wr_beat;
  assign rf_wr_vld  = wr_beat;
  assign rf_wr_data = data_pd;
  assign rf_wr_done = blk_end;

  assign row_beats = total_col[6:1] + {5'd0, total_col[0]};  // two atoms per beat
  assign ccnt_inc  = {1'b0, ccnt} + 6'd1;
  assign rcnt_inc  = {1'b0, rcnt} + 6'd1;
  assign col_end   = wr_beat & (ccnt_inc == row_beats);
  assign blk_end   = col_end & (rcnt_inc == total_row);

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      ccnt       <= '0;
      rcnt       <= '0;
      rf_wr_addr <= '0;
    end else begin
      if (col_end) ccnt <= '0;
      else if (wr_beat) ccnt <= ccnt_inc[4:0];
      if (blk_end) rcnt <= '0;
      else if (col_end) rcnt <= rcnt_inc[4:0];
      if (blk_end) rf_wr_addr <= '0;
      else if (col_end && cfg.mode == mode_contract)
        rf_wr_addr <= ADDR_W'(rcnt_inc * CONTRACT_ROW_STRIDE);  // fixed row stride
      else if (wr_beat) rf_wr_addr <= rf_wr_addr + 1'b1;
    end
  end

  // file only fills off a finished block
  a_full_from_done: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    $rose(rf_full) |-> $past(rf_wr_done));

endmodule

/* tb/rbk_rf_checker.sv */
`timescale 1ns/10ps

module rbk_rf_checker #(
  parameter int DATA_W = 512,
  parameter int ADDR_W = 5
) (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  input  rbk_rf_pkg::rf_cfg_t    cfg,
  input  logic                   wr_cmd_vld,
  input  rbk_rf_pkg::rf_wr_cmd_t wr_cmd,
  input  logic                   wr_cmd_rdy,
  input  logic                   rd_cmd_vld,
  input  rbk_rf_pkg::rf_rd_cmd_t rd_cmd,
  input  logic                   rd_cmd_rdy,
  input  logic                   data_fifo_vld,
  input  logic [DATA_W-1:0]      data_fifo_pd,
  input  logic                   data_fifo_rdy,
  input  logic                   rf_wr_vld,
  input  logic [ADDR_W-1:0]      rf_wr_addr,
  input  logic [DATA_W-1:0]      rf_wr_data,
  input  logic                   rf_wr_done,
  input  logic                   rf_wr_rdy,
  input  logic                   rf_rd_vld,
  input  logic [ADDR_W-1:0]      rf_rd_addr,
  input  rbk_rf_pkg::rf_mask_t   rf_rd_mask,
  input  logic                   rf_rd_done,
  input  logic                   rf_rd_rdy,
  output int                     err_count,
  output int                     wr_beats,
  output int                     rd_beats,
  output int                     wr_blocks,
  output int                     rd_blocks
);
  import rbk_rf_pkg::*;

  localparam int CMD_SLOTS = 3;  // two queued behind one running block

  string      test_name = "reset";  // set by the testbench per test
  rf_wr_cmd_t wr_q[$];
  rf_rd_cmd_t rd_q[$];
  int         wc = 0;  // write beat in row
  int         wr_row = 0;
  int         wk = 0;  // write beat in block
  int         rc = 0;
  int         rd_row = 0;

  initial begin
    err_count = 0;
    wr_beats  = 0;
    rd_beats  = 0;
    wr_blocks = 0;
    rd_blocks = 0;
  end

  task automatic report_value(input string what, input int exp, input int act);
    err_count++;
    $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
  endtask

  task automatic report_fault(input string msg);
    err_count++;
    $display("%s: %s", test_name, msg);
  endtask

  // valid bytes per atom, straight from the mask rule
  function automatic rf_mask_t expect_mask(input rf_rd_cmd_t c, input int beat);
    int       cols;
    int       rem;
    rf_mask_t m;
    cols = int'(c.col_m1) + 1;
    m = '0;
    if (cfg.mode == mode_contract) begin
      rem = cols - 2 * beat;
      m.atom0_bytes = 6'(ATOM_BYTES);
      m.atom1_bytes = (rem == 1) ? 6'd0 : 6'(ATOM_BYTES);
    end else begin
      rem = (cfg.precision == prec_half ? 2 * cols : cols) - 64 * (beat % 4);
      if (rem < 0) rem = 0;  // beat past the end of the row
      if (rem >= 64) begin
        m.atom0_bytes = 6'(ATOM_BYTES);
        m.atom1_bytes = 6'(ATOM_BYTES);
      end else if (rem >= 32) begin
        m.atom0_bytes = 6'(ATOM_BYTES);
        m.atom1_bytes = 6'(rem - 32);
      end else begin
        m.atom0_bytes = 6'(rem);
      end
    end
    return m;
  endfunction

  //////////////////////////////
  // per-cycle compare
  always @(posedge autosa_core_clk) begin : watch
    int  rb;
    int  exp_addr;
    int  cols;
    logic last;
    if (autosa_core_rstn) begin
      if (wr_cmd_rdy !== (wr_q.size() < CMD_SLOTS))
        report_value("write command ready", wr_q.size() < CMD_SLOTS, wr_cmd_rdy);
      if (rd_cmd_rdy !== (rd_q.size() < CMD_SLOTS))
        report_value("read command ready", rd_q.size() < CMD_SLOTS, rd_cmd_rdy);
      if (data_fifo_rdy !== rf_wr_vld) report_fault("data_fifo_rdy differs from rf_wr_vld");
      if (rf_wr_done && !rf_wr_vld) report_fault("write done without a write beat");
      if (rf_rd_done && !rf_rd_vld) report_fault("read done without a read beat");
      if (rf_wr_vld) begin
        if (!rf_wr_rdy || !data_fifo_vld) report_fault("write beat while a permission was low");
        if (wr_blocks - rd_blocks >= RF_SLOTS) report_fault("write beat with both slots full");
        if (rf_wr_data !== data_fifo_pd)
          report_value("write data", int'(data_fifo_pd[31:0]), int'(rf_wr_data[31:0]));
        if (wr_q.size() == 0) begin
          report_fault("write beat with no write command pending");
        end else begin
          rb = (int'(wr_q[0].col_m1) + 2) / 2;
          exp_addr = (cfg.mode == mode_contract) ? wr_row * CONTRACT_ROW_STRIDE + wc : wk;
          exp_addr = exp_addr & ((1 << ADDR_W) - 1);
          last = (wc == rb - 1) && (wr_row == int'(wr_q[0].row_m1));
          if (exp_addr != int'(rf_wr_addr)) report_value("write address", exp_addr, rf_wr_addr);
          if (last != rf_wr_done) report_value("write done", last, rf_wr_done);
          wk++;
          wc++;
          if (wc == rb) begin
            wc = 0;
            wr_row++;
          end
          if (last) begin
            wc = 0;
            wr_row = 0;
            wk = 0;
            void'(wr_q.pop_front());
          end
        end
        wr_beats++;
      end
      if (rf_rd_vld) begin
        if (!rf_rd_rdy) report_fault("read beat while rf_rd_rdy was low");
        if (wr_blocks == rd_blocks) report_fault("read beat before its write block finished");
        if (rd_q.size() == 0) begin
          report_fault("read beat with no read command pending");
        end else begin
          cols = int'(rd_q[0].col_m1) + 1;
          if (cfg.mode == mode_contract) rb = (cols + 1) / 2;
          else rb = (cfg.precision == prec_half && cols > 32) ? 4 : 2;
          exp_addr = (cfg.mode == mode_contract) ? rd_row * CONTRACT_ROW_STRIDE + rc
                                                 : rd_row * SPLIT_ROW_STRIDE + rc;
          exp_addr = exp_addr & ((1 << ADDR_W) - 1);
          last = (rc == rb - 1) && (rd_row == int'(rd_q[0].row_m1));
          if (exp_addr != int'(rf_rd_addr)) report_value("read address", exp_addr, rf_rd_addr);
          if (expect_mask(rd_q[0], rc) != rf_rd_mask)
            report_value("read mask", expect_mask(rd_q[0], rc), rf_rd_mask);
          if (last != rf_rd_done) report_value("read done", last, rf_rd_done);
          rc++;
          if (rc == rb) begin
            rc = 0;
            rd_row++;
          end
          if (last) begin
            rc = 0;
            rd_row = 0;
            void'(rd_q.pop_front());
          end
        end
        rd_beats++;
      end
      if (rf_wr_done) wr_blocks++;
      if (rf_rd_done) rd_blocks++;
      if (wr_cmd_vld && wr_cmd_rdy) wr_q.push_back(wr_cmd);  // after beats, never same cycle
      if (rd_cmd_vld && rd_cmd_rdy) rd_q.push_back(rd_cmd);
    end
  end

endmodule

/* tb/rbk_rf_stimulus.txt */
# name mode prec blocks wr_row_m1 wr_col_m1 rd_row_m1 rd_col_m1 exp_wr_beats exp_rd_beats
# mode 0 contract 1 split, prec 0 byte 1 half, beat counts are per block
contract_even     0 0 1 3 7 3 7 16 16
contract_odd      0 0 1 2 4 2 4 9 9
split_byte        1 0 1 1 3 3 63 4 8
split_half_wide   1 1 1 1 5 3 63 6 16
split_half_narrow 1 1 1 0 1 1 19 1 4
contract_queue    0 0 3 1 3 1 3 4 4
split_byte_queue  1 0 3 0 0 0 63 1 2

/* tb/tb_rbk_rf_ctrl.sv */
`timescale 1ns/10ps

module tb_rbk_rf_ctrl;
  import rbk_rf_pkg::*;

  localparam int DATA_W    = 512;
  localparam int ADDR_W    = 5;
  localparam int MAX_TESTS = 16;

  logic              clk;
  logic              rstn;
  rf_cfg_t           cfg;
  logic              wr_cmd_vld;
  rf_wr_cmd_t        wr_cmd;
  logic              wr_cmd_rdy;
  logic              rd_cmd_vld;
  rf_rd_cmd_t        rd_cmd;
  logic              rd_cmd_rdy;
  logic              data_fifo_vld;
  logic [DATA_W-1:0] data_fifo_pd;
  logic              data_fifo_rdy;
  logic              rf_wr_vld;
  logic [ADDR_W-1:0] rf_wr_addr;
  logic [DATA_W-1:0] rf_wr_data;
  logic              rf_wr_done;
  logic              rf_wr_rdy;
  logic              rf_rd_vld;
  logic [ADDR_W-1:0] rf_rd_addr;
  rf_mask_t          rf_rd_mask;
  logic              rf_rd_done;
  logic              rf_rd_rdy;
  int                err_count;
  int                wr_beats;
  int                rd_beats;
  int                wr_blocks;
  int                rd_blocks;

  string       t_name [MAX_TESTS];
  int          t_val  [MAX_TESTS][9];  // mode prec n wr_row wr_col rd_row rd_col exp_wr exp_rd
  int          n_tests = 0;
  int          tb_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [7:0]  lfsr = 8'd47;
  logic        data_fire = 1'b0;
  logic [31:0] data_cnt = '0;

  rbk_rf_ctrl #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_rbk_rf_ctrl (
    .autosa_core_clk(clk), .autosa_core_rstn(rstn), .cfg(cfg),
    .wr_cmd_vld(wr_cmd_vld), .wr_cmd(wr_cmd), .wr_cmd_rdy(wr_cmd_rdy),
    .rd_cmd_vld(rd_cmd_vld), .rd_cmd(rd_cmd), .rd_cmd_rdy(rd_cmd_rdy),
    .data_fifo_vld(data_fifo_vld), .data_fifo_pd(data_fifo_pd), .data_fifo_rdy(data_fifo_rdy),
    .rf_wr_vld(rf_wr_vld), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data),
    .rf_wr_done(rf_wr_done), .rf_wr_rdy(rf_wr_rdy),
    .rf_rd_vld(rf_rd_vld), .rf_rd_addr(rf_rd_addr), .rf_rd_mask(rf_rd_mask),
    .rf_rd_done(rf_rd_done), .rf_rd_rdy(rf_rd_rdy)
  );

  rbk_rf_checker #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_checker (
    .autosa_core_clk(clk), .autosa_core_rstn(rstn), .cfg(cfg),
    .wr_cmd_vld(wr_cmd_vld), .wr_cmd(wr_cmd), .wr_cmd_rdy(wr_cmd_rdy),
    .rd_cmd_vld(rd_cmd_vld), .rd_cmd(rd_cmd), .rd_cmd_rdy(rd_cmd_rdy),
    .data_fifo_vld(data_fifo_vld), .data_fifo_pd(data_fifo_pd), .data_fifo_rdy(data_fifo_rdy),
    .rf_wr_vld(rf_wr_vld), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data),
    .rf_wr_done(rf_wr_done), .rf_wr_rdy(rf_wr_rdy),
    .rf_rd_vld(rf_rd_vld), .rf_rd_addr(rf_rd_addr), .rf_rd_mask(rf_rd_mask),
    .rf_rd_done(rf_rd_done), .rf_rd_rdy(rf_rd_rdy),
    .err_count(err_count), .wr_beats(wr_beats), .rd_beats(rd_beats),
    .wr_blocks(wr_blocks), .rd_blocks(rd_blocks)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic take_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
    return b;
  endfunction

  //////////////////////////////
  // back-pressure and data
  always @(negedge clk) data_fire = data_fifo_vld & data_fifo_rdy;

  initial begin : pressure
    wait (rstn === 1'b1);
    forever begin
      @(posedge clk);
      #2;
      if (data_fire) data_cnt = data_cnt + 1;
      data_fifo_pd = {16{data_cnt}};
      if (!data_fifo_vld || data_fire) begin  // valid holds until taken
        data_fifo_vld = take_bit();
      end
      rf_wr_rdy = take_bit();
      rf_rd_rdy = take_bit();
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic send_wr(input int i);
    logic fired;
    repeat (t_val[i][2]) begin
      wr_cmd = '{row_m1: 5'(t_val[i][3]), col_m1: 6'(t_val[i][4])};
      wr_cmd_vld = 1'b1;
      do begin
        @(negedge clk);
        fired = wr_cmd_rdy;
        @(posedge clk);
        #2;
      end while (!fired);
      wr_cmd_vld = 1'b0;
    end
  endtask

  task automatic send_rd(input int i);
    logic fired;
    repeat (t_val[i][2]) begin
      rd_cmd = '{row_m1: 6'(t_val[i][5]), col_m1: 6'(t_val[i][6])};
      rd_cmd_vld = 1'b1;
      do begin
        @(negedge clk);
        fired = rd_cmd_rdy;
        @(posedge clk);
        #2;
      end while (!fired);
      rd_cmd_vld = 1'b0;
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp, input int act);
    if (exp != act) begin
      tb_errors++;
      $display("[ERROR] %s %s: expected %0d, actual %0d", name, what, exp, act);
    end
  endtask

  //////////////////////////////
  // main sequence
  initial begin : main
    int    fd;
    int    code;
    int    total;
    int    wb0;
    int    rb0;
    int    wblk0;
    int    rblk0;
    string word;
    string rest;
    rstn = 1'b0;
    cfg = '0;
    wr_cmd_vld = 1'b0;
    wr_cmd = '0;
    rd_cmd_vld = 1'b0;
    rd_cmd = '0;
    data_fifo_vld = 1'b0;
    data_fifo_pd = '0;
    rf_wr_rdy = 1'b0;
    rf_rd_rdy = 1'b0;
    total = 0;
    fd = $fopen("tb/rbk_rf_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        code = $fscanf(fd, "%s", word);
        if (code != 1) break;
        if (word.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          t_name[n_tests] = word;
          for (int k = 0; k < 9; k++) code = $fscanf(fd, "%d", t_val[n_tests][k]);
          total += t_val[n_tests][2] * (t_val[n_tests][7] + t_val[n_tests][8]);
          n_tests++;
        end
      end
      $fclose(fd);
      cycle_limit = total * 8 + 1000;
      repeat (10) @(posedge clk);
      #2;
      rstn = 1'b1;
      for (int i = 0; i < n_tests; i++) begin
        cfg = '{mode: rubik_mode_e'(t_val[i][0]), precision: precision_e'(t_val[i][1])};
        u_checker.test_name = t_name[i];
        wb0 = wr_beats;
        rb0 = rd_beats;
        wblk0 = wr_blocks;
        rblk0 = rd_blocks;
        fork
          send_wr(i);
          send_rd(i);
        join
        while (wr_blocks < wblk0 + t_val[i][2] || rd_blocks < rblk0 + t_val[i][2])
          @(negedge clk);
        @(posedge clk);
        #2;
        check_count(t_name[i], "write beats", t_val[i][2] * t_val[i][7], wr_beats - wb0);
        check_count(t_name[i], "read beats", t_val[i][2] * t_val[i][8], rd_beats - rb0);
      end
      $display("checker errors %0d, beat count errors %0d", err_count, tb_errors);
      if (err_count + tb_errors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

/* vlog.f */
source/rbk_rf_pkg.sv
source/rbk_cmd_fifo.sv
source/rbk_rf_wr_seq.sv
source/rbk_rf_rd_seq.sv
source/rbk_rf_slot_track.sv
source/rbk_rf_ctrl.sv
tb/rbk_rf_checker.sv
tb/tb_rbk_rf_ctrl.sv
